//--- src.f
hdl/soc_pkg.sv
hdl/wb_region_decoder.sv
hdl/wb_periph_router.sv
hdl/wb_sram.sv
hdl/wb_status_regs.sv
hdl/wb_audio_capture.sv
hdl/soc_top.sv
tb/tb_soc_top.sv

//--- tb/tb_soc_top.sv
`default_nettype none

module tb_soc_top;

    localparam int SRAM_WORDS     = 1024;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MAX_WAIT       = 8;     // Cycles before a request counts as lost

    logic                           clk;
    logic                           rst_n_i;
    soc_pkg::wb_req_t               bus_req;
    soc_pkg::wb_rsp_t               bus_rsp;
    logic [soc_pkg::BTN_W-1:0]      buttons;
    logic [soc_pkg::SAMPLE_W-1:0]   sample;
    logic                           sample_valid;
    logic [soc_pkg::LED_W-1:0]      leds;

    integer      seed;
    int          value_errors;
    int          protocol_errors;
    int          cycle_cnt;
    logic [31:0] sram_model [SRAM_WORDS];

    soc_top #(
        .SRAM_WORDS ( SRAM_WORDS )
    ) UUT (
        .clk            ( clk          ),
        .rst_n_i        ( rst_n_i      ),
        .bus_req_i      ( bus_req      ),
        .bus_rsp_o      ( bus_rsp      ),
        .buttons_i      ( buttons      ),
        .sample_i       ( sample       ),
        .sample_valid_i ( sample_valid ),
        .leds_o         ( leds         )
    );

    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // --------------------
    // Address helpers
    function automatic soc_pkg::wb_addr_u region_addr(input int region, input int offset);
        soc_pkg::wb_addr_u a;
        a.region_view.region = soc_pkg::REGION_W'(region);
        a.region_view.offset = soc_pkg::OFFSET_W'(offset);
        return a;
    endfunction

    function automatic soc_pkg::wb_addr_u periph_addr(input int slot, input int idx);
        soc_pkg::wb_addr_u a;
        a.periph_view.region  = soc_pkg::REGION_PERIPH;
        a.periph_view.slot    = soc_pkg::SLOT_W'(slot);
        a.periph_view.reg_idx = soc_pkg::REG_W'(idx);
        return a;
    endfunction

    // Byte lane merge of the memory model
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) result[i*8 +: 8] = new_word[i*8 +: 8];
        end
        return result;
    endfunction

    // --------------------
    // Bus tasks
    task automatic bus_access(input logic we, input soc_pkg::wb_addr_u addr,
                              input logic [31:0] wdata, input logic [3:0] sel,
                              output soc_pkg::wb_rsp_t rsp);
        soc_pkg::wb_req_t req;
        int               waited;
        logic             got;
        req       = '0;
        req.cyc   = 1'b1;
        req.stb   = 1'b1;
        req.we    = we;
        req.addr  = addr;
        req.wdata = wdata;
        req.sel   = sel;
        waited    = 0;
        got       = 1'b0;
        @(posedge clk);
        bus_req <= req;
        while (!got && waited < MAX_WAIT) begin
            @(posedge clk);
            waited++;
            @(negedge clk);  // Response settled here
            if (bus_rsp.ack || bus_rsp.err) got = 1'b1;
        end
        rsp = bus_rsp;
        if (!got) begin
            protocol_errors++;
            $display("No ack or err came back for address %h", addr);
        end else if (waited != 1) begin
            protocol_errors++;
            $display("Response for address %h came after %0d cycles, not 1", addr, waited);
        end
        if (bus_rsp.ack && bus_rsp.err) begin
            protocol_errors++;
            $display("Ack and err were high together for address %h", addr);
        end
        @(posedge clk);
        bus_req.cyc <= 1'b0;
        bus_req.stb <= 1'b0;
    endtask

    task automatic bus_write(input soc_pkg::wb_addr_u addr, input logic [31:0] wdata,
                             input logic [3:0] sel, output soc_pkg::wb_rsp_t rsp);
        bus_access(1'b1, addr, wdata, sel, rsp);
    endtask

    task automatic bus_read(input soc_pkg::wb_addr_u addr, output soc_pkg::wb_rsp_t rsp);
        bus_access(1'b0, addr, 32'h0, 4'hf, rsp);
    endtask

    // --------------------
    // Check tasks
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic expect_ack(input soc_pkg::wb_rsp_t rsp, input string what);
        if (!rsp.ack || rsp.err) begin
            protocol_errors++;
            $display("Access to %s was not acknowledged (ack %0b, err %0b)", what, rsp.ack,
                     rsp.err);
        end
    endtask

    task automatic expect_err(input soc_pkg::wb_rsp_t rsp, input string what);
        if (!rsp.err || rsp.ack) begin
            protocol_errors++;
            $display("Access to %s did not return err alone (ack %0b, err %0b)", what,
                     rsp.ack, rsp.err);
        end
        if (rsp.rdata !== 32'h0) begin
            value_errors++;
            $display("Fail bus_rsp_o.rdata: expected %h, got %h", 32'h0, rsp.rdata);
        end
    endtask

    // Single cycle strobe on the audio input
    task automatic pulse_sample(input logic [11:0] value);
        @(posedge clk);
        sample       <= value;
        sample_valid <= 1'b1;
        @(posedge clk);
        sample_valid <= 1'b0;
    endtask

    // --------------------
    // Directed tests
    task automatic test_reset_state();
        soc_pkg::wb_rsp_t rsp;
        @(negedge clk);
        check_value("leds_o", 32'h0, 32'(leds));
        bus_read(periph_addr(soc_pkg::SLOT_STATUS, 0), rsp);
        expect_ack(rsp, "status register 0");
        check_value("status reg 0", 32'h0, rsp.rdata);
        bus_read(periph_addr(soc_pkg::SLOT_AUDIO, 1), rsp);
        expect_ack(rsp, "audio register 1");
        check_value("audio reg 1", 32'h0, rsp.rdata);
    endtask

    task automatic test_sram();
        soc_pkg::wb_rsp_t rsp;
        int               addrs [6];
        logic [31:0]      data;
        addrs = '{0, 1, 5, 37, 100, SRAM_WORDS - 1};
        foreach (addrs[i]) begin
            data = $random(seed);
            bus_write(region_addr(soc_pkg::REGION_SRAM, addrs[i]), data, 4'hf, rsp);
            expect_ack(rsp, "SRAM write");
            sram_model[addrs[i]] = data;
        end
        // Only lane 2 of word 5 changes
        data = $random(seed);
        bus_write(region_addr(soc_pkg::REGION_SRAM, 5), data, 4'b0100, rsp);
        expect_ack(rsp, "SRAM lane write");
        sram_model[5] = merge_lanes(sram_model[5], data, 4'b0100);
        foreach (addrs[i]) begin
            bus_read(region_addr(soc_pkg::REGION_SRAM, addrs[i]), rsp);
            expect_ack(rsp, "SRAM read");
            check_value("sram rdata", sram_model[addrs[i]], rsp.rdata);
        end
    endtask

    task automatic test_unmapped();
        soc_pkg::wb_rsp_t rsp;
        bus_read(region_addr(2, 0), rsp);
        expect_err(rsp, "region 2");
        bus_read(region_addr(soc_pkg::REGION_SRAM, SRAM_WORDS), rsp);
        expect_err(rsp, "SRAM offset past the end");
        bus_write(periph_addr(3, 0), 32'hdead_beef, 4'hf, rsp);
        expect_err(rsp, "peripheral slot 3");
        bus_read(region_addr(soc_pkg::REGION_SRAM, 37), rsp);
        expect_ack(rsp, "SRAM after errors");
        check_value("sram rdata", sram_model[37], rsp.rdata);
    endtask

    task automatic test_status();
        soc_pkg::wb_rsp_t rsp;
        logic [31:0]      data;
        data = $random(seed);
        bus_write(periph_addr(soc_pkg::SLOT_STATUS, 0), data, 4'b0001, rsp);
        expect_ack(rsp, "LED register write");
        check_value("leds_o", 32'(data[2:0]), 32'(leds));
        bus_read(periph_addr(soc_pkg::SLOT_STATUS, 0), rsp);
        expect_ack(rsp, "LED register read");
        check_value("status reg 0", 32'(data[2:0]), rsp.rdata);
        @(posedge clk);
        buttons <= 2'b10;
        repeat (4) @(posedge clk);  // Through the synchroniser
        bus_read(periph_addr(soc_pkg::SLOT_STATUS, 1), rsp);
        expect_ack(rsp, "button register");
        check_value("status reg 1", 32'h2, rsp.rdata);
    endtask

    task automatic test_audio();
        soc_pkg::wb_rsp_t rsp;
        logic [11:0]      neg;
        neg = 12'ha53;
        pulse_sample(neg);
        bus_read(periph_addr(soc_pkg::SLOT_AUDIO, 0), rsp);
        expect_ack(rsp, "audio sample");
        check_value("audio reg 0", 32'hffff_fa53, rsp.rdata);
        bus_read(periph_addr(soc_pkg::SLOT_AUDIO, 1), rsp);
        expect_ack(rsp, "audio status");
        check_value("audio reg 1", 32'h0000_0001, rsp.rdata);
        // Second strobe lands on an unread sample
        pulse_sample(12'h123);
        pulse_sample(12'h7ff);
        bus_read(periph_addr(soc_pkg::SLOT_AUDIO, 1), rsp);
        expect_ack(rsp, "audio status");
        check_value("audio reg 1", 32'h8000_0003, rsp.rdata);
        bus_read(periph_addr(soc_pkg::SLOT_AUDIO, 0), rsp);
        expect_ack(rsp, "audio sample");
        check_value("audio reg 0", 32'h0000_07ff, rsp.rdata);
        bus_read(periph_addr(soc_pkg::SLOT_AUDIO, 1), rsp);
        expect_ack(rsp, "audio status");
        check_value("audio reg 1", 32'h0000_0003, rsp.rdata);
    endtask

    // --------------------
    initial begin
        seed            = 26;
        value_errors    = 0;
        protocol_errors = 0;
        cycle_cnt       = 0;
        clk             = 1'b0;
        rst_n_i         = 1'b0;
        bus_req         = '0;
        buttons         = '0;
        sample          = '0;
        sample_valid    = 1'b0;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;

        test_reset_state();
        test_sram();
        test_unmapped();
        test_status();
        test_audio();

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/soc_top.sv
`default_nettype none

module soc_top #(
    parameter int SRAM_WORDS = 1024
) (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  soc_pkg::wb_req_t              bus_req_i,
    output soc_pkg::wb_rsp_t              bus_rsp_o,
    input  wire [soc_pkg::BTN_W-1:0]      buttons_i,
    input  wire [soc_pkg::SAMPLE_W-1:0]   sample_i,
    input  wire                           sample_valid_i,
    output logic [soc_pkg::LED_W-1:0]     leds_o
);

    soc_pkg::wb_req_t sram_req;
    soc_pkg::wb_rsp_t sram_rsp;
    soc_pkg::wb_req_t periph_req;
    soc_pkg::wb_rsp_t periph_rsp;
    soc_pkg::wb_req_t status_req;
    soc_pkg::wb_rsp_t status_rsp;
    soc_pkg::wb_req_t audio_req;
    soc_pkg::wb_rsp_t audio_rsp;

    // --------------------
    // Fabric
    wb_region_decoder #(
        .SRAM_WORDS ( SRAM_WORDS )
    ) u_region_decoder (
        .clk          ( clk        ),
        .rst_n_i      ( rst_n_i    ),
        .m_req_i      ( bus_req_i  ),
        .m_rsp_o      ( bus_rsp_o  ),
        .sram_req_o   ( sram_req   ),
        .sram_rsp_i   ( sram_rsp   ),
        .periph_req_o ( periph_req ),
        .periph_rsp_i ( periph_rsp )
    );

    wb_periph_router u_periph_router (
        .clk          ( clk        ),
        .rst_n_i      ( rst_n_i    ),
        .m_req_i      ( periph_req ),
        .m_rsp_o      ( periph_rsp ),
        .status_req_o ( status_req ),
        .status_rsp_i ( status_rsp ),
        .audio_req_o  ( audio_req  ),
        .audio_rsp_i  ( audio_rsp  )
    );

    // --------------------
    // Slaves
    wb_sram #(
        .SRAM_WORDS ( SRAM_WORDS )
    ) u_sram (
        .clk     ( clk      ),
        .rst_n_i ( rst_n_i  ),
        .req_i   ( sram_req ),
        .rsp_o   ( sram_rsp )
    );

    wb_status_regs u_status_regs (
        .clk       ( clk        ),
        .rst_n_i   ( rst_n_i    ),
        .req_i     ( status_req ),
        .rsp_o     ( status_rsp ),
        .buttons_i ( buttons_i  ),
        .leds_o    ( leds_o     )
    );

    wb_audio_capture u_audio_capture (
        .clk            ( clk            ),
        .rst_n_i        ( rst_n_i        ),
        .req_i          ( audio_req      ),
        .rsp_o          ( audio_rsp      ),
        .sample_i       ( sample_i       ),
        .sample_valid_i ( sample_valid_i )
    );

endmodule

`default_nettype wire

//--- hdl/wb_audio_capture.sv
`default_nettype none

module wb_audio_capture (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  soc_pkg::wb_req_t             req_i,
    output soc_pkg::wb_rsp_t             rsp_o,
    input  wire [soc_pkg::SAMPLE_W-1:0]  sample_i,
    input  wire                          sample_valid_i
);

    localparam int PAD_W = soc_pkg::DATA_W - 1 - soc_pkg::SAMPLE_CNT_W;

    logic [soc_pkg::SAMPLE_W-1:0]     sample_q;
    logic [soc_pkg::SAMPLE_CNT_W-1:0] cnt_q;
    logic                             unread_q;
    logic                             overrun_q;
    logic [soc_pkg::DATA_W-1:0]       rdata_q;
    logic [soc_pkg::REG_W-1:0]        reg_idx;
    logic                             ack_q;
    logic                             accept;
    logic                             rd_sample;

    assign reg_idx   = req_i.addr.periph_view.reg_idx;
    assign accept    = req_i.cyc & req_i.stb & ~ack_q;
    assign rd_sample = accept & ~req_i.we & (reg_idx == '0);

    always_ff @(posedge clk) begin
        if (sample_valid_i) begin
            sample_q <= sample_i;
        end
    end

    // --------------------
    // Count and overrun tracking
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            cnt_q     <= '0;
            unread_q  <= 1'b0;
            overrun_q <= 1'b0;
        end else begin
            ack_q <= accept;
            if (rd_sample) begin
                unread_q  <= 1'b0;
                overrun_q <= 1'b0;
            end
            if (sample_valid_i) begin
                cnt_q    <= cnt_q + 1'b1;  // Wraps
                unread_q <= 1'b1;
                if (unread_q && !rd_sample) begin
                    overrun_q <= 1'b1;
                end
            end
        end
    end

    // Writes are ignored
    always_ff @(posedge clk) begin
        if (accept && !req_i.we) begin
            case (reg_idx)
                soc_pkg::REG_W'(0):
                    rdata_q <= {{(soc_pkg::DATA_W - soc_pkg::SAMPLE_W){sample_q[soc_pkg::SAMPLE_W-1]}},
                                sample_q};
                soc_pkg::REG_W'(1): rdata_q <= {overrun_q, {PAD_W{1'b0}}, cnt_q};
                default:            rdata_q <= '0;
            endcase
        end
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.err   = 1'b0;
    assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

//--- hdl/wb_status_regs.sv
`default_nettype none

module wb_status_regs (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  soc_pkg::wb_req_t           req_i,
    output soc_pkg::wb_rsp_t           rsp_o,
    input  wire [soc_pkg::BTN_W-1:0]   buttons_i,
    output logic [soc_pkg::LED_W-1:0]  leds_o
);

    logic [soc_pkg::BTN_W-1:0]  btn_meta;
    logic [soc_pkg::BTN_W-1:0]  btn_sync;
    logic [soc_pkg::DATA_W-1:0] rdata_q;
    logic [soc_pkg::REG_W-1:0]  reg_idx;
    logic                       ack_q;
    logic                       accept;

    assign reg_idx = req_i.addr.periph_view.reg_idx;
    assign accept  = req_i.cyc & req_i.stb & ~ack_q;

    // Two flop button synchroniser
    always_ff @(posedge clk) begin
        btn_meta <= buttons_i;
        btn_sync <= btn_meta;
    end

    // --------------------
    // Control and LED register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            leds_o <= '0;
        end else begin
            ack_q <= accept;
            // LEDs live in lane 0
            if (accept && req_i.we && req_i.sel[0] && reg_idx == '0) begin
                leds_o <= req_i.wdata[soc_pkg::LED_W-1:0];
            end
        end
    end

    // Unused registers read zero
    always_ff @(posedge clk) begin
        if (accept && !req_i.we) begin
            case (reg_idx)
                soc_pkg::REG_W'(0): rdata_q <= soc_pkg::DATA_W'(leds_o);
                soc_pkg::REG_W'(1): rdata_q <= soc_pkg::DATA_W'(btn_sync);
                default:            rdata_q <= '0;
            endcase
        end
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.err   = 1'b0;
    assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

//--- hdl/wb_sram.sv
`default_nettype none

module wb_sram #(
    parameter int SRAM_WORDS = 1024
) (
    input  wire               clk,
    input  wire               rst_n_i,
    input  soc_pkg::wb_req_t  req_i,
    output soc_pkg::wb_rsp_t  rsp_o
);

    localparam int IDX_W = $clog2(SRAM_WORDS);

    logic [soc_pkg::DATA_W-1:0] mem [SRAM_WORDS];
    logic [soc_pkg::DATA_W-1:0] rdata_q;
    logic [IDX_W-1:0]           idx;
    logic                       ack_q;
    logic                       accept;

    assign idx    = req_i.addr.region_view.offset[IDX_W-1:0];
    assign accept = req_i.cyc & req_i.stb & ~ack_q;

    // --------------------
    // Storage with byte lane writes
    always_ff @(posedge clk) begin
        if (accept && req_i.we) begin
            for (int i = 0; i < soc_pkg::SEL_W; i++) begin
                if (req_i.sel[i]) begin
                    mem[idx][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
                end
            end
        end
        if (accept && !req_i.we) begin
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;  // Single cycle ack
        end
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.err   = 1'b0;
    assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

//--- hdl/wb_periph_router.sv
`default_nettype none

module wb_periph_router (
    input  wire               clk,
    input  wire               rst_n_i,

    input  soc_pkg::wb_req_t  m_req_i,
    output soc_pkg::wb_rsp_t  m_rsp_o,

    output soc_pkg::wb_req_t  status_req_o,
    input  soc_pkg::wb_rsp_t  status_rsp_i,

    output soc_pkg::wb_req_t  audio_req_o,
    input  soc_pkg::wb_rsp_t  audio_rsp_i
);

    logic hit_status;
    logic hit_audio;
    logic err_q;

    assign hit_status = (m_req_i.addr.periph_view.slot == soc_pkg::SLOT_STATUS);
    assign hit_audio  = (m_req_i.addr.periph_view.slot == soc_pkg::SLOT_AUDIO);

    always_comb begin
        status_req_o     = m_req_i;
        status_req_o.stb = m_req_i.stb & hit_status;
        audio_req_o      = m_req_i;
        audio_req_o.stb  = m_req_i.stb & hit_audio;
    end

    // Unmapped slot answers here
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= m_req_i.cyc & m_req_i.stb & ~hit_status & ~hit_audio & ~err_q;
        end
    end

    always_comb begin
        if (err_q) begin
            m_rsp_o     = '0;
            m_rsp_o.err = 1'b1;
        end else if (hit_status) begin
            m_rsp_o = status_rsp_i;
        end else if (hit_audio) begin
            m_rsp_o = audio_rsp_i;
        end else begin
            m_rsp_o = '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/wb_region_decoder.sv
`default_nettype none

module wb_region_decoder #(
    parameter int SRAM_WORDS = 1024
) (
    input  wire               clk,
    input  wire               rst_n_i,

    input  soc_pkg::wb_req_t  m_req_i,
    output soc_pkg::wb_rsp_t  m_rsp_o,

    output soc_pkg::wb_req_t  sram_req_o,
    input  soc_pkg::wb_rsp_t  sram_rsp_i,

    output soc_pkg::wb_req_t  periph_req_o,
    input  soc_pkg::wb_rsp_t  periph_rsp_i
);

    logic hit_sram;
    logic hit_periph;
    logic unmapped;
    logic err_q;

    // --------------------
    // Region decode
    assign hit_sram = (m_req_i.addr.region_view.region == soc_pkg::REGION_SRAM) &&
                      (m_req_i.addr.region_view.offset < soc_pkg::OFFSET_W'(SRAM_WORDS));
    assign hit_periph = (m_req_i.addr.region_view.region == soc_pkg::REGION_PERIPH);
    assign unmapped   = !hit_sram && !hit_periph;

    // Only the selected target sees stb
    always_comb begin
        sram_req_o       = m_req_i;
        sram_req_o.stb   = m_req_i.stb & hit_sram;
        periph_req_o     = m_req_i;
        periph_req_o.stb = m_req_i.stb & hit_periph;
    end

    // Error responder pulses for one cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= m_req_i.cyc & m_req_i.stb & unmapped & ~err_q;
        end
    end

    // --------------------
    // Response return
    always_comb begin
        if (err_q) begin
            m_rsp_o       = '0;
            m_rsp_o.err   = 1'b1;  // rdata stays zero
        end else if (hit_sram) begin
            m_rsp_o = sram_rsp_i;
        end else if (hit_periph) begin
            m_rsp_o = periph_rsp_i;
        end else begin
            m_rsp_o = '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Bus widths
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;
    localparam int ADDR_W = 30;           // Word address

    // Address fields
    localparam int REGION_W = 4;
    localparam int SLOT_W   = 4;
    localparam int REG_W    = 22;
    localparam int OFFSET_W = ADDR_W - REGION_W;

    // --------------------
    // Address map
    localparam logic [REGION_W-1:0] REGION_SRAM   = 4'd0;
    localparam logic [REGION_W-1:0] REGION_PERIPH = 4'd4;
    localparam logic [SLOT_W-1:0]   SLOT_STATUS   = 4'd0;
    localparam logic [SLOT_W-1:0]   SLOT_AUDIO    = 4'd1;

    // Device sizes
    localparam int LED_W        = 3;
    localparam int BTN_W        = 2;
    localparam int SAMPLE_W     = 12;
    localparam int SAMPLE_CNT_W = 16;

    // --------------------
    // One word address with two decode views
    typedef union packed {
        struct packed {
            logic [REGION_W-1:0] region;
            logic [OFFSET_W-1:0] offset;
        } region_view;
        struct packed {
            logic [REGION_W-1:0] region;
            logic [SLOT_W-1:0]   slot;
            logic [REG_W-1:0]    reg_idx;
        } periph_view;
    } wb_addr_u;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        wb_addr_u          addr;
        logic [DATA_W-1:0] wdata;
        logic [SEL_W-1:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] rdata;
    } wb_rsp_t;

endpackage

`default_nettype wire
